/* common/serial_acc_cfg.svh */
`ifndef SERIAL_ACC_CFG_SVH
`define SERIAL_ACC_CFG_SVH

// clocks per serial bit on both lines.
`define SACC_CLK_PER_BIT 8

// result queue slots and the starting credit count.
// must be a power of two.
`define SACC_QUEUE_DEPTH 4

// opcode byte values.
`define SACC_OP_LOAD 8'h01
`define SACC_OP_ADD  8'h02
`define SACC_OP_XOR  8'h03
`define SACC_OP_READ 8'h04

`endif

/* common/serial_acc_pkg.sv */
`default_nettype none
`include "serial_acc_cfg.svh"

package serial_acc_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [63:0] word_t;

    // holds zero up to the full queue depth.
    typedef logic [$clog2(`SACC_QUEUE_DEPTH + 1)-1:0] credit_t;

    typedef enum logic [1:0] {
        OP_LOAD,
        OP_ADD,
        OP_XOR,
        OP_READ
    } acc_op_e;

    typedef struct packed {
        acc_op_e op;
        word_t   operand;
    } acc_cmd_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START_BIT,
        TX_DATA,
        TX_STOP_BIT
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START_BIT,
        RX_DATA,
        RX_STOP_BIT
    } rx_state_e;

endpackage

`default_nettype wire

/* project.f */
+incdir+common
common/serial_acc_pkg.sv
uart/uart_rx.sv
uart/word_tx.sv
rtl/cmd_decode.sv
rtl/acc_execute.sv
rtl/result_queue.sv
rtl/serial_acc_top.sv
tb/acc_checker.sv
tb/tb_serial_acc.sv

/* rtl/acc_execute.sv */
`timescale 1ns/1ps
`default_nettype none
`include "serial_acc_cfg.svh"

module acc_execute
    import serial_acc_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     cmd_valid,
    input  wire acc_cmd_t cmd,
    output logic          cmd_ready,
    output logic          res_push,
    output word_t         res_word,
    input  wire logic     credit_return
);

    localparam credit_t MAX_CREDITS = credit_t'(`SACC_QUEUE_DEPTH);

    credit_t credits;
    word_t   acc;
    word_t   acc_next;
    logic    accept;

    assign cmd_ready = (credits != '0);
    assign accept    = cmd_valid && cmd_ready;
    assign res_word  = acc; // new value sits here while res_push is high.

    always_comb begin
        unique case (cmd.op)
            OP_LOAD: acc_next = cmd.operand;
            OP_ADD:  acc_next = acc + cmd.operand; // wraps mod 2^64.
            OP_XOR:  acc_next = acc ^ cmd.operand;
            OP_READ: acc_next = acc;
            default: acc_next = acc;
        endcase
    end

    // credit spent at acceptance and push one cycle later.
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= MAX_CREDITS;
        end else begin
            case ({accept, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc      <= '0;
            res_push <= 1'b0;
        end else begin
            res_push <= accept;
            if (accept) acc <= acc_next;
        end
    end

    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits <= MAX_CREDITS);

endmodule

`default_nettype wire

/* rtl/cmd_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "serial_acc_cfg.svh"

module cmd_decode
    import serial_acc_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  rx_valid,
    input  wire byte_t rx_byte,
    output logic       cmd_valid,
    output acc_cmd_t   cmd,
    input  wire logic  cmd_ready,
    output logic       bad_op,
    output logic       overrun
);

    logic [3:0] byte_cnt;
    byte_t      opcode;
    word_t      operand_sr;
    word_t      operand_next;
    acc_op_e    op_map;
    logic       op_known;
    logic       frame_end;
    logic       held;
    logic       load_cmd;

    assign operand_next = {rx_byte, operand_sr[63:8]};
    assign frame_end    = rx_valid && (byte_cnt == 4'd8);
    assign held         = cmd_valid && !cmd_ready; // not leaving this cycle.
    assign load_cmd     = frame_end && op_known && !held;

    always_comb begin
        op_known = 1'b1;
        op_map   = OP_READ;
        case (opcode)
            `SACC_OP_LOAD: op_map = OP_LOAD;
            `SACC_OP_ADD:  op_map = OP_ADD;
            `SACC_OP_XOR:  op_map = OP_XOR;
            `SACC_OP_READ: op_map = OP_READ;
            default:       op_known = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_cnt  <= '0;
            cmd_valid <= 1'b0;
            bad_op    <= 1'b0;
            overrun   <= 1'b0;
        end else begin
            if (rx_valid) byte_cnt <= frame_end ? 4'd0 : byte_cnt + 1'b1;
            if (cmd_valid && cmd_ready) cmd_valid <= 1'b0;
            if (frame_end) begin
                if (!op_known) bad_op <= 1'b1;
                else if (held) overrun <= 1'b1; // new frame is dropped.
                else cmd_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && byte_cnt == 4'd0) opcode <= rx_byte;
        if (rx_valid && byte_cnt != 4'd0) operand_sr <= operand_next;
        if (load_cmd) cmd <= '{op: op_map, operand: operand_next};
    end

    a_cmd_stable: assert property (@(posedge clk) disable iff (rst)
        held |=> $stable(cmd));

endmodule

`default_nettype wire

/* rtl/result_queue.sv */
`timescale 1ns/1ps
`default_nettype none
`include "serial_acc_cfg.svh"

module result_queue
    import serial_acc_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  res_push,
    input  wire word_t res_word,
    output logic       credit_return,
    input  wire logic  tx_busy,
    output logic       tx_start,
    output word_t      tx_word
);

    localparam int      DEPTH = `SACC_QUEUE_DEPTH;
    localparam int      PTR_W = $clog2(DEPTH);
    localparam credit_t FULL  = credit_t'(DEPTH);

    word_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    credit_t          count;
    logic             pop;

    // launch head word whenever the transmitter is free.
    assign pop           = (count != '0) && !tx_busy;
    assign tx_start      = pop;
    assign credit_return = pop; // a freed slot goes back as a credit.
    assign tx_word       = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (res_push) mem[wr_ptr] <= res_word;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (res_push) wr_ptr <= wr_ptr + 1'b1; // wraps since depth is a power of two.
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({res_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        res_push |-> (count != FULL));

endmodule

`default_nettype wire

/* rtl/serial_acc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_acc_top
    import serial_acc_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic rx,
    output logic      tx,
    output logic      bad_op,
    output logic      overrun
);

    logic     rx_valid;
    byte_t    rx_byte;
    logic     cmd_valid;
    logic     cmd_ready;
    acc_cmd_t cmd;
    logic     res_push;
    word_t    res_word;
    logic     credit_return;
    logic     tx_busy;
    logic     tx_start;
    word_t    tx_word;

    uart_rx u_uart_rx (
        .clk(clk), .rst(rst), .rx(rx), .rx_valid(rx_valid), .rx_byte(rx_byte)
    );

    cmd_decode u_cmd_decode (
        .clk(clk), .rst(rst), .rx_valid(rx_valid), .rx_byte(rx_byte),
        .cmd_valid(cmd_valid), .cmd(cmd), .cmd_ready(cmd_ready),
        .bad_op(bad_op), .overrun(overrun)
    );

    acc_execute u_acc_execute (
        .clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd(cmd), .cmd_ready(cmd_ready),
        .res_push(res_push), .res_word(res_word), .credit_return(credit_return)
    );

    result_queue u_result_queue (
        .clk(clk), .rst(rst), .res_push(res_push), .res_word(res_word),
        .credit_return(credit_return), .tx_busy(tx_busy),
        .tx_start(tx_start), .tx_word(tx_word)
    );

    word_tx u_word_tx (
        .clk(clk), .rst(rst), .tx_start(tx_start), .tx_word(tx_word),
        .tx(tx), .busy(tx_busy)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the serial accumulator testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_serial_acc \
    -f project.f -o sim_serial_acc
./obj_dir/sim_serial_acc | tee sim.log
if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

/* tb/acc_cases.txt */
# name burst(1 = next frame at once) opcode operand expect_word expected_word flags
# flags are {overrun, bad_op} as they should read after the case.
read_after_reset 0 04 0000000000000000 1 0000000000000000 0
load_a 0 01 123456789abcdef0 1 123456789abcdef0 0
read_a 0 04 ffffffffffffffff 1 123456789abcdef0 0
add_small 0 02 0000000000000010 1 123456789abcdf00 0
load_near_max 0 01 fffffffffffffff0 1 fffffffffffffff0 0
add_wrap 0 02 0000000000000025 1 0000000000000015 0
add_big 0 02 8000000000000000 1 8000000000000015 0
add_wrap_big 0 02 8000000000000001 1 0000000000000016 0
xor_mask 0 03 a5a5a5a5a5a5a5a5 1 a5a5a5a5a5a5a5b3 0
xor_invert 0 03 ffffffffffffffff 1 5a5a5a5a5a5a5a4c 0
bad_opcode 0 7e 1111111111111111 0 0000000000000000 1
read_after_bad 0 04 0000000000000000 1 5a5a5a5a5a5a5a4c 1
burst_load 1 01 0000000000000001 1 0000000000000001 1
burst_add1 1 02 0000000000000002 1 0000000000000003 1
burst_xor 1 03 00000000000000ff 1 00000000000000fc 1
burst_add_wrap 1 02 ffffffffffffff04 1 0000000000000000 1
burst_add2 1 02 0123456789abcdef 1 0123456789abcdef 1
burst_read 0 04 0000000000000000 1 0123456789abcdef 1
tail_load 1 01 00000000deadbeef 1 00000000deadbeef 1
tail_add 1 02 0000000100000000 1 00000001deadbeef 1
tail_xor 1 03 ffffffff00000000 1 fffffffedeadbeef 1
tail_extra_read 0 04 0000000000000000 1 fffffffedeadbeef 1

/* tb/acc_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "serial_acc_cfg.svh"

module acc_checker
    import serial_acc_pkg::*;
#(
    parameter int NAME_W = 192
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              tx,
    input  wire logic              bad_op,
    input  wire logic              overrun,
    input  wire logic              exp_push,
    input  wire logic              flag_check,
    input  wire logic [NAME_W-1:0] case_name,
    input  wire word_t             exp_word,
    input  wire logic [1:0]        exp_flags,
    output int                     words_seen,
    output int                     pass_cnt,
    output int                     fail_cnt
);

    localparam int CPB = `SACC_CLK_PER_BIT;

    logic [NAME_W-1:0] name_q[$];
    word_t             word_q[$];
    logic [1:0]        flags_q[$];
    logic              in_byte;
    int                wait_cnt;
    int                bit_n;
    int                byte_n;
    byte_t             cur_byte;
    word_t             cur_word;

    task automatic judge_test(input logic [NAME_W-1:0] name, input logic has_word,
                              input word_t exp, input word_t got, input logic [1:0] exp_fl);
        logic [1:0] act;
        act = {overrun, bad_op};
        if (has_word && got != exp) begin
            fail_cnt = fail_cnt + 1;
            $display("Mismatch %0s: word expected %h actual %h", name, exp, got);
        end else if (act != exp_fl) begin
            fail_cnt = fail_cnt + 1;
            $display("Mismatch %0s: flags {overrun,bad_op} expected %b actual %b",
                     name, exp_fl, act);
        end else begin
            pass_cnt = pass_cnt + 1;
            if (has_word) $display("PASS %0s: word %h flags %b", name, got, act);
            else $display("PASS %0s: no word, flags %b", name, act);
        end
    endtask

    task automatic take_word(input word_t got);
        words_seen = words_seen + 1;
        if (word_q.size() == 0) begin
            fail_cnt = fail_cnt + 1;
            $display("unexpected word %h arrived while no test was waiting for one", got);
        end else begin
            judge_test(name_q.pop_front(), 1'b1, word_q.pop_front(), got, flags_q.pop_front());
        end
    endtask

    // tx only moves on rising edges, so the falling edge sees it settled.
    always @(negedge clk) begin
        if (rst) begin
            in_byte    = 1'b0;
            wait_cnt   = 0;
            bit_n      = 0;
            byte_n     = 0;
            words_seen = 0;
            pass_cnt   = 0;
            fail_cnt   = 0;
            name_q.delete();
            word_q.delete();
            flags_q.delete();
        end else begin
            if (exp_push) begin
                name_q.push_back(case_name);
                word_q.push_back(exp_word);
                flags_q.push_back(exp_flags);
            end
            if (flag_check) judge_test(case_name, 1'b0, '0, '0, exp_flags);
            if (!in_byte) begin
                if (!tx) begin // start bit begins.
                    in_byte  = 1'b1;
                    wait_cnt = CPB / 2 - 1;
                    bit_n    = 0;
                end
            end else if (wait_cnt != 0) begin
                wait_cnt = wait_cnt - 1;
            end else begin
                wait_cnt = CPB - 1; // next mid-bit.
                case (bit_n)
                    0: begin
                        if (tx) begin
                            fail_cnt = fail_cnt + 1;
                            $display("start bit of response byte %0d was high at mid-bit", byte_n);
                            in_byte = 1'b0;
                        end
                    end
                    9: begin
                        if (!tx) begin
                            fail_cnt = fail_cnt + 1;
                            $display("stop bit of response byte %0d read low", byte_n);
                        end
                        in_byte  = 1'b0;
                        cur_word = {cur_byte, cur_word[63:8]}; // bytes arrive lsb first.
                        if (byte_n == 7) begin
                            byte_n = 0;
                            take_word(cur_word);
                        end else begin
                            byte_n = byte_n + 1;
                        end
                    end
                    default: cur_byte = {tx, cur_byte[7:1]};
                endcase
                bit_n = bit_n + 1;
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_serial_acc.sv */
`timescale 1ns/1ps
`default_nettype none
`include "serial_acc_cfg.svh"

module tb_serial_acc
    import serial_acc_pkg::*;
();

    localparam int CPB       = `SACC_CLK_PER_BIT;
    localparam int FRAME_CYC = 9 * 10 * CPB; // one command frame on the line.
    localparam int MAX_CASES = 64;
    localparam int NAME_W    = 8 * 24;

    logic              clk = 1'b0;
    logic              rst;
    logic              rx;
    logic              tx;
    logic              bad_op;
    logic              overrun;
    logic              exp_push;
    logic              flag_check;
    logic [NAME_W-1:0] case_name;
    word_t             exp_word;
    logic [1:0]        exp_flags;
    int                words_seen;
    int                pass_cnt;
    int                fail_cnt;

    logic [NAME_W-1:0] names [MAX_CASES];
    logic              burst [MAX_CASES];
    byte_t             opcodes [MAX_CASES];
    word_t             operands [MAX_CASES];
    logic              resp [MAX_CASES];
    word_t             expected [MAX_CASES];
    logic [1:0]        flags [MAX_CASES];
    int                n_cases;
    int                pushed;
    int                limit = 0;
    int                cycles = 0;
    logic              load_ok;

    serial_acc_top UUT (
        .clk(clk), .rst(rst), .rx(rx), .tx(tx), .bad_op(bad_op), .overrun(overrun)
    );

    acc_checker #(.NAME_W(NAME_W)) u_checker (
        .clk(clk), .rst(rst), .tx(tx), .bad_op(bad_op), .overrun(overrun),
        .exp_push(exp_push), .flag_check(flag_check), .case_name(case_name),
        .exp_word(exp_word), .exp_flags(exp_flags), .words_seen(words_seen),
        .pass_cnt(pass_cnt), .fail_cnt(fail_cnt)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: run reached %0d cycles without finishing", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic load_cases();
        int                fd;
        int                n;
        int                b;
        int                r;
        string             line;
        logic [NAME_W-1:0] nm;
        byte_t             op;
        word_t             opd;
        word_t             ew;
        logic [1:0]        fl;
        logic              bad_line;
        n_cases  = 0;
        bad_line = 1'b0;
        fd = $fopen("tb/acc_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/acc_cases.txt");
        end else begin
            while (!$feof(fd) && n_cases < MAX_CASES) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %d %h %h %d %h %h", nm, b, op, opd, r, ew, fl);
                    if (n == 7) begin
                        names[n_cases]    = nm;
                        burst[n_cases]    = (b != 0);
                        opcodes[n_cases]  = op;
                        operands[n_cases] = opd;
                        resp[n_cases]     = (r != 0);
                        expected[n_cases] = ew;
                        flags[n_cases]    = fl;
                        n_cases = n_cases + 1;
                    end else begin
                        $display("malformed case line: %s", line);
                        bad_line = 1'b1;
                    end
                end
            end
            $fclose(fd);
        end
        load_ok = (n_cases > 0) && !bad_line;
        limit   = n_cases * (9 + 8) * 10 * CPB * 3;
    endtask

    task automatic drive_bit(input logic v);
        @(posedge clk);
        #1 rx = v;
        repeat (CPB - 1) @(posedge clk);
    endtask

    task automatic send_byte(input byte_t b);
        int i;
        drive_bit(1'b0);
        for (i = 0; i < 8; i++) drive_bit(b[i]);
        drive_bit(1'b1);
    endtask

    task automatic send_frame(input byte_t op, input word_t operand);
        int i;
        send_byte(op);
        for (i = 0; i < 8; i++) send_byte(operand[8*i +: 8]); // lsb byte first.
    endtask

    // one-cycle pulse that hands this case's expectations to the checker.
    task automatic notify_checker(input int i, input logic is_word);
        @(posedge clk);
        #1;
        case_name = names[i];
        exp_word  = expected[i];
        exp_flags = flags[i];
        if (is_word) exp_push = 1'b1;
        else flag_check = 1'b1;
        @(posedge clk);
        #1;
        exp_push   = 1'b0;
        flag_check = 1'b0;
    endtask

    task automatic wait_responses();
        while (words_seen != pushed) @(posedge clk);
    endtask

    task automatic run_cases();
        int i;
        for (i = 0; i < n_cases; i++) begin
            if (resp[i]) begin
                notify_checker(i, 1'b1);
                pushed = pushed + 1;
            end
            send_frame(opcodes[i], operands[i]);
            if (!resp[i]) begin
                repeat (2 * FRAME_CYC) @(posedge clk); // no word may show up here.
                notify_checker(i, 1'b0);
            end else if (!burst[i]) begin
                wait_responses();
            end
        end
        wait_responses();
        repeat (2 * FRAME_CYC) @(posedge clk); // room for a stray word.
    endtask

    initial begin
        rst        = 1'b1;
        rx         = 1'b1;
        exp_push   = 1'b0;
        flag_check = 1'b0;
        case_name  = '0;
        exp_word   = '0;
        exp_flags  = '0;
        pushed     = 0;
        load_cases();
        if (!load_ok) begin
            $display("no usable test cases, stopping");
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            repeat (10) @(posedge clk);
            #1 rst = 1'b0;
            run_cases();
            if (fail_cnt == 0 && pass_cnt != n_cases)
                $display("only %0d of %0d tests reported a result", pass_cnt, n_cases);
            $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
            if (fail_cnt == 0 && pass_cnt == n_cases) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* uart/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none
`include "serial_acc_cfg.svh"

module uart_rx
    import serial_acc_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic rx,
    output logic      rx_valid,
    output byte_t     rx_byte
);

    localparam int CPB   = `SACC_CLK_PER_BIT;
    localparam int CTR_W = $clog2(CPB);

    rx_state_e        state;
    logic [CTR_W-1:0] ctr;
    logic [2:0]       bit_idx;
    logic             rx_meta;
    logic             rx_sync;

    // two flops in front of everything else.
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RX_IDLE;
            ctr      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    ctr     <= '0;
                    bit_idx <= '0;
                    if (!rx_sync) state <= RX_START_BIT; // falling edge.
                end
                RX_START_BIT: begin
                    ctr <= ctr + 1'b1;
                    if (ctr == CTR_W'(CPB / 2 - 1)) begin
                        ctr   <= '0;
                        state <= rx_sync ? RX_IDLE : RX_DATA; // line back high means a glitch.
                    end
                end
                RX_DATA: begin
                    ctr <= ctr + 1'b1;
                    if (ctr == CTR_W'(CPB - 1)) begin
                        ctr     <= '0;
                        rx_byte <= {rx_sync, rx_byte[7:1]}; // lsb arrives first.
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= RX_STOP_BIT;
                    end
                end
                RX_STOP_BIT: begin
                    ctr <= ctr + 1'b1;
                    if (ctr == CTR_W'(CPB - 1)) begin
                        rx_valid <= rx_sync; // bad stop bit drops the byte.
                        state    <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    a_rx_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

/* uart/word_tx.sv */
`timescale 1ns/1ps
`default_nettype none
`include "serial_acc_cfg.svh"

module word_tx
    import serial_acc_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  tx_start,
    input  wire word_t tx_word,
    output logic       tx,
    output logic       busy
);

    localparam int CPB   = `SACC_CLK_PER_BIT;
    localparam int CTR_W = $clog2(CPB);

    tx_state_e        state;
    logic [CTR_W-1:0] ctr;
    logic [2:0]       bit_idx;
    logic [2:0]       byte_idx;
    word_t            shift_word;
    logic             bit_done;

    assign bit_done = (ctr == CTR_W'(CPB - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= TX_IDLE;
            ctr      <= '0;
            bit_idx  <= '0;
            byte_idx <= '0;
            tx       <= 1'b1;
            busy     <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    tx       <= 1'b1;
                    ctr      <= '0;
                    bit_idx  <= '0;
                    byte_idx <= '0;
                    if (tx_start) begin
                        shift_word <= tx_word;
                        tx         <= 1'b0; // start bit of byte 0.
                        busy       <= 1'b1;
                        state      <= TX_START_BIT;
                    end
                end
                TX_START_BIT: begin
                    ctr <= ctr + 1'b1;
                    if (bit_done) begin
                        ctr        <= '0;
                        tx         <= shift_word[0];
                        shift_word <= shift_word >> 1;
                        state      <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    ctr <= ctr + 1'b1;
                    if (bit_done) begin
                        ctr <= '0;
                        if (bit_idx == 3'd7) begin
                            bit_idx <= '0;
                            tx      <= 1'b1;
                            state   <= TX_STOP_BIT;
                        end else begin
                            bit_idx    <= bit_idx + 1'b1;
                            tx         <= shift_word[0];
                            shift_word <= shift_word >> 1;
                        end
                    end
                end
                TX_STOP_BIT: begin
                    ctr <= ctr + 1'b1;
                    if (bit_done) begin
                        ctr <= '0;
                        if (byte_idx == 3'd7) begin
                            busy  <= 1'b0; // word done.
                            state <= TX_IDLE;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                            tx       <= 1'b0;
                            state    <= TX_START_BIT;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
        tx_start |-> !busy);

endmodule

`default_nettype wire
